//--- decode_issue.f
logic/issue_pkg.sv
logic/instr_decoder.sv
logic/operand_resolver.sv
logic/dispatch_control.sv
logic/issue_register.sv
logic/decode_issue.sv
verif/issue_checker.sv
verif/decode_issue_tb.sv

//--- logic/decode_issue.sv
`timescale 1ns/1ps
`default_nettype none

module decode_issue (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             flush_i,
    input  logic                             i_queue_empty_i,
    input  issue_pkg::queue_entry_t          instr_i,
    output logic                             i_queue_read_o,
    input  issue_pkg::regfile_entry_t        regfile_entry_i,
    output logic [issue_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [issue_pkg::TAG_W-1:0]      tag_o,
    output logic                             load_tag_o,
    input  logic [issue_pkg::TAG_W-1:0]      rob_free_tag_i,
    input  issue_pkg::rob_view_t             rob_view_i,
    input  logic                             rob_full_i,
    output logic                             rob_write_o,
    output issue_pkg::rob_entry_t            rob_entry_o,
    input  logic                             alu_rs_full_i,
    output issue_pkg::alu_issue_t            alu_issue_o,
    input  logic                             cmp_rs_full_i,
    output issue_pkg::cmp_issue_t            cmp_issue_o,
    input  logic                             lsb_full_i,
    input  logic                             lsb_almost_full_i,
    output issue_pkg::lsb_issue_t            lsb_issue_o
);

    issue_pkg::decoded_instr_t decoded;
    issue_pkg::operand_t       src_a;
    issue_pkg::operand_t       src_b;
    logic                      fire;

    // regfile read ports straight from the decoded fields
    assign rs1_o = decoded.rs1;
    assign rs2_o = decoded.rs2;

    instr_decoder u_decoder (
        .instr_i   (instr_i),
        .decoded_o (decoded)
    );

    operand_resolver u_resolver (
        .clk             (clk),
        .reset_i         (reset_i),
        .flush_i         (flush_i),
        .decoded_i       (decoded),
        .regfile_entry_i (regfile_entry_i),
        .rob_view_i      (rob_view_i),
        .fire_i          (fire),
        .rename_tag_i    (tag_o),
        .src_a_o         (src_a),
        .src_b_o         (src_b)
    );

    dispatch_control u_dispatch (
        .reset_i           (reset_i),
        .flush_i           (flush_i),
        .decoded_i         (decoded),
        .i_queue_empty_i   (i_queue_empty_i),
        .rob_free_tag_i    (rob_free_tag_i),
        .rob_full_i        (rob_full_i),
        .alu_rs_full_i     (alu_rs_full_i),
        .cmp_rs_full_i     (cmp_rs_full_i),
        .lsb_full_i        (lsb_full_i),
        .lsb_almost_full_i (lsb_almost_full_i),
        .fire_o            (fire),
        .i_queue_read_o    (i_queue_read_o),
        .rd_o              (rd_o),
        .tag_o             (tag_o),
        .load_tag_o        (load_tag_o)
    );

    issue_register u_issue (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .fire_i         (fire),
        .decoded_i      (decoded),
        .src_a_i        (src_a),
        .src_b_i        (src_b),
        .rob_free_tag_i (rob_free_tag_i),
        .alu_issue_o    (alu_issue_o),
        .cmp_issue_o    (cmp_issue_o),
        .lsb_issue_o    (lsb_issue_o),
        .rob_write_o    (rob_write_o),
        .rob_entry_o    (rob_entry_o)
    );

endmodule

`default_nettype wire

//--- logic/dispatch_control.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_control (
    input  logic                             reset_i,
    input  logic                             flush_i,
    input  issue_pkg::decoded_instr_t        decoded_i,
    input  logic                             i_queue_empty_i,
    input  logic [issue_pkg::TAG_W-1:0]      rob_free_tag_i,
    input  logic                             rob_full_i,
    input  logic                             alu_rs_full_i,
    input  logic                             cmp_rs_full_i,
    input  logic                             lsb_full_i,
    input  logic                             lsb_almost_full_i,
    output logic                             fire_o,
    output logic                             i_queue_read_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [issue_pkg::TAG_W-1:0]      tag_o,
    output logic                             load_tag_o
);

    logic active;
    logic discard;
    logic unit_busy;

    assign active = !reset_i && !flush_i && !i_queue_empty_i && !rob_full_i;

    // illegal, or result would land in x0
    assign discard = !decoded_i.legal || (decoded_i.writes_rd && decoded_i.rd == '0);

    // almost full holds back memory ops only
    always_comb begin
        case (decoded_i.unit)
            issue_pkg::unit_alu: unit_busy = alu_rs_full_i;
            issue_pkg::unit_cmp: unit_busy = cmp_rs_full_i;
            issue_pkg::unit_lsb: unit_busy = lsb_full_i || lsb_almost_full_i;
            default:             unit_busy = 1'b1;
        endcase
    end

    assign fire_o = active && !discard && rob_free_tag_i != '0 && !unit_busy;

    assign i_queue_read_o = fire_o || (active && discard);

    // rename write to the register file
    assign load_tag_o = fire_o && decoded_i.writes_rd;
    assign rd_o       = decoded_i.rd;
    assign tag_o      = load_tag_o ? rob_free_tag_i : '0;

endmodule

`default_nettype wire

//--- logic/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  issue_pkg::queue_entry_t   instr_i,
    output issue_pkg::decoded_instr_t decoded_o
);

    logic [31:0]                word;
    issue_pkg::opcode_e         opcode;
    logic [2:0]                 funct3;
    logic                       funct7_5;
    logic                       sub_sra;
    logic [issue_pkg::XLEN-1:0] i_imm;
    logic [issue_pkg::XLEN-1:0] s_imm;
    logic [issue_pkg::XLEN-1:0] b_imm;
    logic [issue_pkg::XLEN-1:0] u_imm;

    assign word     = instr_i.word;
    assign opcode   = issue_pkg::opcode_e'(word[6:0]);
    assign funct3   = word[14:12];
    assign funct7_5 = word[30];

    assign i_imm = {{21{word[31]}}, word[30:20]};
    assign s_imm = {{21{word[31]}}, word[30:25], word[11:7]};
    assign b_imm = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    assign u_imm = {word[31:12], 12'h000};

    // funct7[5] selects sub only in the register group, sra/srai in both
    assign sub_sra = funct7_5 &&
                     (funct3 == 3'b101 || (opcode == issue_pkg::op_reg && funct3 == 3'b000));

    always_comb begin
        decoded_o        = '0;
        decoded_o.pc     = instr_i.pc;
        decoded_o.opcode = opcode;
        decoded_o.rs1    = word[19:15];
        decoded_o.rs2    = word[24:20];
        decoded_o.rd     = word[11:7];
        decoded_o.funct3 = funct3;
        decoded_o.alu_op = issue_pkg::alu_add;
        decoded_o.unit   = issue_pkg::unit_none;
        decoded_o.legal  = 1'b1;

        case (opcode)
            issue_pkg::op_lui, issue_pkg::op_auipc: begin
                decoded_o.unit       = issue_pkg::unit_alu;
                decoded_o.imm        = u_imm;
                decoded_o.imm_is_b   = 1'b1;
                decoded_o.a_replaced = 1'b1;
                decoded_o.a_sel_pc   = (opcode == issue_pkg::op_auipc);
                decoded_o.writes_rd  = 1'b1;
            end
            issue_pkg::op_br: begin
                decoded_o.unit = issue_pkg::unit_cmp;
                decoded_o.imm  = b_imm;
            end
            issue_pkg::op_load: begin
                decoded_o.unit      = issue_pkg::unit_lsb;
                decoded_o.imm       = i_imm;
                decoded_o.writes_rd = 1'b1;
            end
            issue_pkg::op_store: begin
                decoded_o.unit = issue_pkg::unit_lsb;
                decoded_o.imm  = s_imm;
            end
            issue_pkg::op_imm, issue_pkg::op_reg: begin
                decoded_o.writes_rd = 1'b1;
                if (opcode == issue_pkg::op_imm) begin
                    decoded_o.imm      = i_imm;
                    decoded_o.imm_is_b = 1'b1;
                end
                // slt and sltu go to the compare station
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    decoded_o.unit = issue_pkg::unit_cmp;
                end else begin
                    decoded_o.unit   = issue_pkg::unit_alu;
                    decoded_o.alu_op = issue_pkg::alu_op_e'({sub_sra, funct3});
                end
            end
            default: begin
                decoded_o.legal = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/issue_pkg.sv
`default_nettype none

package issue_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ROB_DEPTH  = 8;
    // tag 0 is reserved for "no producer"
    localparam int TAG_W      = 3;

    // RV32I major opcodes handled by this stage
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // low three bits follow funct3, top bit is funct7[5]
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_op_e;

    typedef enum logic [1:0] {
        unit_none,
        unit_alu,
        unit_cmp,
        unit_lsb
    } unit_e;

    // head of the instruction queue
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     word;
    } queue_entry_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        unit_e                 unit;
        alu_op_e               alu_op;
        // compare op or memory width
        logic [2:0]            funct3;
        logic [XLEN-1:0]       imm;
        logic                  imm_is_b;
        // operand a taken from pc or zero instead of rs1
        logic                  a_replaced;
        logic                  a_sel_pc;
        logic                  writes_rd;
        logic                  legal;
    } decoded_instr_t;

    typedef struct packed {
        logic [XLEN-1:0]  value;
        logic [TAG_W-1:0] tag;
        logic             ready;
    } operand_t;

    typedef struct packed {
        logic [XLEN-1:0]  vj;
        logic [TAG_W-1:0] qj;
        logic [XLEN-1:0]  vk;
        logic [TAG_W-1:0] qk;
    } regfile_entry_t;

    typedef struct packed {
        logic            ready;
        logic [XLEN-1:0] value;
    } rob_slot_t;

    typedef struct packed {
        rob_slot_t [ROB_DEPTH-1:0] slot;
    } rob_view_t;

    typedef struct packed {
        logic             valid;
        alu_op_e          op;
        operand_t         src_a;
        operand_t         src_b;
        logic [TAG_W-1:0] tag;
    } alu_issue_t;

    typedef struct packed {
        logic             valid;
        logic             is_branch;
        logic [2:0]       funct3;
        operand_t         src_a;
        operand_t         src_b;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  offset;
        logic [TAG_W-1:0] tag;
    } cmp_issue_t;

    typedef struct packed {
        logic             valid;
        logic             is_store;
        logic [2:0]       funct3;
        operand_t         base;
        operand_t         data;
        logic [XLEN-1:0]  offset;
        logic [TAG_W-1:0] tag;
    } lsb_issue_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
    } rob_entry_t;

endpackage

`default_nettype wire

//--- logic/issue_register.sv
`timescale 1ns/1ps
`default_nettype none

module issue_register (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        flush_i,
    input  logic                        fire_i,
    input  issue_pkg::decoded_instr_t   decoded_i,
    input  issue_pkg::operand_t         src_a_i,
    input  issue_pkg::operand_t         src_b_i,
    input  logic [issue_pkg::TAG_W-1:0] rob_free_tag_i,
    output issue_pkg::alu_issue_t       alu_issue_o,
    output issue_pkg::cmp_issue_t       cmp_issue_o,
    output issue_pkg::lsb_issue_t       lsb_issue_o,
    output logic                        rob_write_o,
    output issue_pkg::rob_entry_t       rob_entry_o
);

    issue_pkg::operand_t opnd_a;
    issue_pkg::operand_t opnd_b;
    issue_pkg::operand_t zero_opnd;
    logic                is_branch;
    logic                is_store;

    assign is_branch = (decoded_i.opcode == issue_pkg::op_br);
    assign is_store  = (decoded_i.opcode == issue_pkg::op_store);

    always_comb begin
        zero_opnd       = '0;
        zero_opnd.ready = 1'b1;

        // lui takes zero, auipc takes pc
        opnd_a = src_a_i;
        if (decoded_i.a_replaced) begin
            opnd_a       = zero_opnd;
            opnd_a.value = decoded_i.a_sel_pc ? decoded_i.pc : '0;
        end

        opnd_b = src_b_i;
        if (decoded_i.imm_is_b) begin
            opnd_b       = zero_opnd;
            opnd_b.value = decoded_i.imm;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            alu_issue_o.valid <= 1'b0;
            cmp_issue_o.valid <= 1'b0;
            lsb_issue_o.valid <= 1'b0;
            rob_write_o       <= 1'b0;
        end else begin
            alu_issue_o.valid <= fire_i && decoded_i.unit == issue_pkg::unit_alu;
            cmp_issue_o.valid <= fire_i && decoded_i.unit == issue_pkg::unit_cmp;
            lsb_issue_o.valid <= fire_i && decoded_i.unit == issue_pkg::unit_lsb;
            rob_write_o       <= fire_i;
        end

        // payloads only; valid bits above pick the unit
        if (fire_i) begin
            alu_issue_o.op    <= decoded_i.alu_op;
            alu_issue_o.src_a <= opnd_a;
            alu_issue_o.src_b <= opnd_b;
            alu_issue_o.tag   <= rob_free_tag_i;

            cmp_issue_o.is_branch <= is_branch;
            cmp_issue_o.funct3    <= decoded_i.funct3;
            cmp_issue_o.src_a     <= opnd_a;
            cmp_issue_o.src_b     <= opnd_b;
            cmp_issue_o.pc        <= decoded_i.pc;
            cmp_issue_o.offset    <= is_branch ? decoded_i.imm : '0;
            cmp_issue_o.tag       <= rob_free_tag_i;

            // loads carry no store data
            lsb_issue_o.is_store <= is_store;
            lsb_issue_o.funct3   <= decoded_i.funct3;
            lsb_issue_o.base     <= opnd_a;
            lsb_issue_o.data     <= is_store ? opnd_b : zero_opnd;
            lsb_issue_o.offset   <= decoded_i.imm;
            lsb_issue_o.tag      <= rob_free_tag_i;

            rob_entry_o.pc     <= decoded_i.pc;
            rob_entry_o.opcode <= decoded_i.opcode;
            rob_entry_o.rd     <= decoded_i.writes_rd ? decoded_i.rd : '0;
        end
    end

endmodule

`default_nettype wire

//--- logic/operand_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module operand_resolver (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            flush_i,
    input  issue_pkg::decoded_instr_t       decoded_i,
    input  issue_pkg::regfile_entry_t       regfile_entry_i,
    input  issue_pkg::rob_view_t            rob_view_i,
    input  logic                            fire_i,
    input  logic [issue_pkg::TAG_W-1:0]     rename_tag_i,
    output issue_pkg::operand_t             src_a_o,
    output issue_pkg::operand_t             src_b_o
);

    // rd and tag renamed by the last cycle's fire
    logic [issue_pkg::REG_ADDR_W-1:0] prev_rd;
    logic [issue_pkg::TAG_W-1:0]      prev_tag;

    function automatic issue_pkg::operand_t resolve(
        input logic [issue_pkg::REG_ADDR_W-1:0] src,
        input logic [issue_pkg::XLEN-1:0]       rf_value,
        input logic [issue_pkg::TAG_W-1:0]      rf_tag
    );
        issue_pkg::operand_t opnd;
        opnd = '0;
        if (src == '0) begin
            opnd.ready = 1'b1;
        end else if (src == prev_rd) begin
            // producer issued one cycle ago, not yet visible in the regfile
            opnd.tag = prev_tag;
        end else if (rf_tag != '0 && rob_view_i.slot[rf_tag].ready) begin
            opnd.value = rob_view_i.slot[rf_tag].value;
            opnd.ready = 1'b1;
        end else begin
            opnd.value = rf_value;
            opnd.tag   = rf_tag;
            opnd.ready = (rf_tag == '0);
        end
        return opnd;
    endfunction

    always_comb begin
        src_a_o = resolve(decoded_i.rs1, regfile_entry_i.vj, regfile_entry_i.qj);
        src_b_o = resolve(decoded_i.rs2, regfile_entry_i.vk, regfile_entry_i.qk);
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            prev_rd  <= '0;
            prev_tag <= '0;
        end else if (fire_i && decoded_i.writes_rd) begin
            prev_rd  <= decoded_i.rd;
            prev_tag <= rename_tag_i;
        end else begin
            prev_rd  <= '0;
            prev_tag <= '0;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module decode_issue_tb \
    -f decode_issue.f -o decode_issue_sim

output=$(./obj_dir/decode_issue_sim)
echo "$output"

if echo "$output" | grep -q "^Testbench passed$"; then
    exit 0
fi
exit 1

//--- verif/decode_issue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_issue_tb;

    localparam int MAX_LINES = 200;
    localparam int N_COLS    = 25;

    logic clk;
    logic reset_i;
    logic flush_i;
    logic i_queue_empty_i;
    logic rob_full_i;
    logic alu_rs_full_i;
    logic cmp_rs_full_i;
    logic lsb_full_i;
    logic lsb_almost_full_i;
    logic [issue_pkg::TAG_W-1:0] rob_free_tag_i;
    issue_pkg::queue_entry_t     instr_i;
    issue_pkg::regfile_entry_t   regfile_entry_i;
    issue_pkg::rob_view_t        rob_view_i;

    logic                             i_queue_read_o;
    logic [issue_pkg::REG_ADDR_W-1:0] rs1_o;
    logic [issue_pkg::REG_ADDR_W-1:0] rs2_o;
    logic [issue_pkg::REG_ADDR_W-1:0] rd_o;
    logic [issue_pkg::TAG_W-1:0]      tag_o;
    logic                             load_tag_o;
    logic                             rob_write_o;
    issue_pkg::rob_entry_t            rob_entry_o;
    issue_pkg::alu_issue_t            alu_issue_o;
    issue_pkg::cmp_issue_t            cmp_issue_o;
    issue_pkg::lsb_issue_t            lsb_issue_o;

    logic [31:0] col [N_COLS];
    logic [31:0] exp_cols [15];
    logic        check_en;
    int          line_no;
    int          n_lines;
    int          n_read;
    int          fd;
    int          trace_errors;
    int          checks;
    int          errors;
    logic        timed_out;
    string       text;

    always #4 clk = ~clk;

    decode_issue dut (.*);

    issue_checker u_checker (
        .clk            (clk),
        .enable_i       (check_en),
        .line_i         (line_no),
        .pc_i           (instr_i.pc),
        .word_i         (instr_i.word),
        .exp_i          (exp_cols),
        .i_queue_read_i (i_queue_read_o),
        .rs1_i          (rs1_o),
        .rs2_i          (rs2_o),
        .load_tag_i     (load_tag_o),
        .rd_i           (rd_o),
        .tag_i          (tag_o),
        .alu_issue_i    (alu_issue_o),
        .cmp_issue_i    (cmp_issue_o),
        .lsb_issue_i    (lsb_issue_o),
        .rob_write_i    (rob_write_o),
        .rob_entry_i    (rob_entry_o),
        .check_count_o  (checks),
        .error_count_o  (errors)
    );

    // hex columns of one trace line into col, returns how many were found
    function automatic int split_columns(input string line);
        return $sscanf(line,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            col[0], col[1], col[2], col[3], col[4], col[5], col[6],
            col[7], col[8], col[9], col[10], col[11], col[12], col[13],
            col[14], col[15], col[16], col[17], col[18], col[19],
            col[20], col[21], col[22], col[23], col[24]);
    endfunction

    // column 0 packs the control flags, rob slot i holds rbase + i
    task automatic apply_line();
        int i;
        {lsb_almost_full_i, lsb_full_i, cmp_rs_full_i, alu_rs_full_i,
         rob_full_i, i_queue_empty_i, flush_i} = col[0][6:0];
        instr_i.pc         = col[1];
        instr_i.word       = col[2];
        regfile_entry_i.vj = col[3];
        regfile_entry_i.qj = col[4][2:0];
        regfile_entry_i.vk = col[5];
        regfile_entry_i.qk = col[6][2:0];
        rob_free_tag_i     = col[7][2:0];
        for (i = 0; i < issue_pkg::ROB_DEPTH; i++) begin
            rob_view_i.slot[i].ready = col[8][i];
            rob_view_i.slot[i].value = col[9] + 32'(i);
        end
        for (i = 0; i < 15; i++) begin
            exp_cols[i] = col[10 + i];
        end
    endtask

    initial begin
        clk = 1'b0;
        reset_i = 1'b1;
        flush_i = 1'b0;
        i_queue_empty_i = 1'b1;
        rob_full_i = 1'b0;
        alu_rs_full_i = 1'b0;
        cmp_rs_full_i = 1'b0;
        lsb_full_i = 1'b0;
        lsb_almost_full_i = 1'b0;
        rob_free_tag_i = '0;
        instr_i = '0;
        regfile_entry_i = '0;
        rob_view_i = '0;
        exp_cols = '{default: 32'h0};
        check_en = 1'b0;
        line_no = 0;
        trace_errors = 0;
        timed_out = 1'b0;

        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;

        fd = $fopen("verif/decode_issue_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            trace_errors++;
        end else begin
            n_lines = 0;
            while (!$feof(fd) && !timed_out) begin
                n_lines++;
                if (n_lines > MAX_LINES) begin
                    timed_out = 1'b1;
                    $display("trace did not end within %0d lines", MAX_LINES);
                end else begin
                    n_read = $fgets(text, fd);
                    if (n_read > 4 && text.getc(0) != 8'h23) begin
                        n_read = split_columns(text);
                        if (n_read != N_COLS) begin
                            $display("trace line %0d has %0d columns", n_lines, n_read);
                            trace_errors++;
                        end else begin
                            @(posedge clk);
                            #1;
                            apply_line();
                            line_no = n_lines;
                            check_en = 1'b1;
                        end
                    end
                end
            end
            $fclose(fd);
        end

        // one more cycle so the records of the last line get compared
        @(posedge clk);
        @(negedge clk);
        #1;
        $display("checks %0d, value errors %0d, trace errors %0d", checks, errors, trace_errors);
        if (errors == 0 && trace_errors == 0 && !timed_out && checks > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/decode_issue_trace.txt
# flags pc word vj qj vk qk free rmask rbase | read ld rd tag | vmask op av at ar bv bt br rtag off robrd
# flags: 0 flush, 1 queue empty, 2 rob full, 3 alu full, 4 cmp full, 5 lsb full, 6 lsb almost full
# vmask: 0 alu, 1 cmp, 2 lsb, 3 rob write, 4 branch or store; records are due one cycle later
00 100 002081B3 11 0 22 0 1 00 0   1 1 03 1   09 0 11 0 1 22 0 1 1 0 03
00 104 40518233 77 0 55 0 2 00 0   1 1 04 2   09 8 0 1 0 55 0 1 2 0 04
00 108 40325313 0 0 0 0 3 00 0   1 1 06 3   09 D 0 2 0 403 0 1 3 0 06
00 10C 123453B7 11 0 22 0 4 00 0   1 1 07 4   09 0 0 0 1 12345000 0 1 4 0 07
00 110 00001417 11 0 22 0 5 00 0   1 1 08 5   09 0 110 0 1 1000 0 1 5 0 08
00 114 00B504B3 AA 2 99 3 6 04 500   1 1 09 6   09 0 502 0 1 99 3 0 6 0 09
00 120 00208863 11 0 22 0 7 00 0   1 0 10 0   1A 0 11 0 1 22 0 1 7 10 00
00 124 FFF0A613 11 0 22 0 1 00 0   1 1 0C 1   0A 2 11 0 1 FFFFFFFF 0 1 1 0 0C
00 128 0020B6B3 11 0 22 0 2 00 0   1 1 0D 2   0A 3 11 0 1 22 0 1 2 0 0D
00 12C 0080A703 11 0 22 0 3 00 0   1 1 0E 3   0C 2 11 0 1 0 0 1 3 8 0E
40 130 0020A623 11 0 22 0 4 00 0   0 0 0C 0   00 0 0 0 0 0 0 0 0 0 00
40 134 002087B3 11 0 22 0 4 00 0   1 1 0F 4   09 0 11 0 1 22 0 1 4 0 0F
00 130 0020A623 11 0 22 0 5 00 0   1 0 0C 0   1C 2 11 0 1 22 0 1 5 C 00
04 138 002081B3 11 0 22 0 6 00 0   0 0 03 0   00 0 0 0 0 0 0 0 0 0 00
00 138 002081B3 11 0 22 0 0 00 0   0 0 03 0   00 0 0 0 0 0 0 0 0 0 00
08 138 002081B3 11 0 22 0 6 00 0   0 0 03 0   00 0 0 0 0 0 0 0 0 0 00
02 0 00000000 0 0 0 0 6 00 0   0 0 00 0   00 0 0 0 0 0 0 0 0 0 00
00 13C 00208033 11 0 22 0 6 00 0   1 0 00 0   00 0 0 0 0 0 0 0 0 0 00
00 140 0000007F 11 0 22 0 6 00 0   1 0 00 0   00 0 0 0 0 0 0 0 0 0 00
00 144 002081B3 11 0 22 0 6 00 0   1 1 03 6   09 0 11 0 1 22 0 1 6 0 03
01 148 40518233 77 0 55 0 7 00 0   0 0 04 0   00 0 0 0 0 0 0 0 0 0 00
00 148 40518233 77 0 55 0 7 00 0   1 1 04 7   09 8 77 0 1 55 0 1 7 0 04
02 0 00000000 0 0 0 0 0 00 0   0 0 00 0   00 0 0 0 0 0 0 0 0 0 00

//--- verif/issue_checker.sv
`timescale 1ns/1ps
`default_nettype none

module issue_checker (
    input  logic                             clk,
    input  logic                             enable_i,
    input  int                               line_i,
    input  logic [31:0]                      pc_i,
    input  logic [31:0]                      word_i,
    input  logic [31:0]                      exp_i [15],
    input  logic                             i_queue_read_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic                             load_tag_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [issue_pkg::TAG_W-1:0]      tag_i,
    input  issue_pkg::alu_issue_t            alu_issue_i,
    input  issue_pkg::cmp_issue_t            cmp_issue_i,
    input  issue_pkg::lsb_issue_t            lsb_issue_i,
    input  logic                             rob_write_i,
    input  issue_pkg::rob_entry_t            rob_entry_i,
    output int                               check_count_o,
    output int                               error_count_o
);

    // expected records of the line whose cycle just ended
    logic [31:0] pend [15] = '{default: 32'h0};
    logic [31:0] pend_pc = '0;
    logic [31:0] pend_word = '0;
    int          checks = 0;
    int          errors = 0;

    assign check_count_o = checks;
    assign error_count_o = errors;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] line %0d %s got %h expected %h", line_i, name, got, exp);
        end
    endtask

    task automatic compare_operand(input string name, input issue_pkg::operand_t got,
                                   input int base);
        compare_field({name, ".value"}, got.value, pend[base]);
        compare_field({name, ".tag"}, 32'(got.tag), pend[base + 1]);
        compare_field({name, ".ready"}, 32'(got.ready), pend[base + 2]);
    endtask

    always @(posedge clk) begin
        if (enable_i) begin
            pend      <= exp_i;
            pend_pc   <= pc_i;
            pend_word <= word_i;
        end
    end

    // pend: 4 valid mask, 5 op, 6..8 src a, 9..11 src b, 12 tag, 13 offset, 14 rob rd
    always @(negedge clk) begin
        if (enable_i) begin
            compare_field("i_queue_read_o", 32'(i_queue_read_i), exp_i[0]);
            compare_field("load_tag_o", 32'(load_tag_i), exp_i[1]);
            compare_field("rd_o", 32'(rd_i), exp_i[2]);
            compare_field("tag_o", 32'(tag_i), exp_i[3]);

            // source fields sit at the same bits in every RV32I format
            compare_field("rs1_o", 32'(rs1_i), 32'(word_i[19:15]));
            compare_field("rs2_o", 32'(rs2_i), 32'(word_i[24:20]));

            compare_field("alu_issue_o.valid", 32'(alu_issue_i.valid), 32'(pend[4][0]));
            compare_field("cmp_issue_o.valid", 32'(cmp_issue_i.valid), 32'(pend[4][1]));
            compare_field("lsb_issue_o.valid", 32'(lsb_issue_i.valid), 32'(pend[4][2]));
            compare_field("rob_write_o", 32'(rob_write_i), 32'(pend[4][3]));

            if (alu_issue_i.valid && pend[4][0]) begin
                compare_field("alu_issue_o.op", 32'(alu_issue_i.op), pend[5]);
                compare_operand("alu_issue_o.src_a", alu_issue_i.src_a, 6);
                compare_operand("alu_issue_o.src_b", alu_issue_i.src_b, 9);
                compare_field("alu_issue_o.tag", 32'(alu_issue_i.tag), pend[12]);
            end
            if (cmp_issue_i.valid && pend[4][1]) begin
                compare_field("cmp_issue_o.is_branch", 32'(cmp_issue_i.is_branch),
                              32'(pend[4][4]));
                compare_field("cmp_issue_o.funct3", 32'(cmp_issue_i.funct3), pend[5]);
                compare_operand("cmp_issue_o.src_a", cmp_issue_i.src_a, 6);
                compare_operand("cmp_issue_o.src_b", cmp_issue_i.src_b, 9);
                compare_field("cmp_issue_o.pc", cmp_issue_i.pc, pend_pc);
                compare_field("cmp_issue_o.offset", cmp_issue_i.offset, pend[13]);
                compare_field("cmp_issue_o.tag", 32'(cmp_issue_i.tag), pend[12]);
            end
            if (lsb_issue_i.valid && pend[4][2]) begin
                compare_field("lsb_issue_o.is_store", 32'(lsb_issue_i.is_store),
                              32'(pend[4][4]));
                compare_field("lsb_issue_o.funct3", 32'(lsb_issue_i.funct3), pend[5]);
                compare_operand("lsb_issue_o.base", lsb_issue_i.base, 6);
                compare_operand("lsb_issue_o.data", lsb_issue_i.data, 9);
                compare_field("lsb_issue_o.offset", lsb_issue_i.offset, pend[13]);
                compare_field("lsb_issue_o.tag", 32'(lsb_issue_i.tag), pend[12]);
            end
            if (rob_write_i && pend[4][3]) begin
                compare_field("rob_entry_o.rd", 32'(rob_entry_i.rd), pend[14]);
                compare_field("rob_entry_o.pc", rob_entry_i.pc, pend_pc);
                compare_field("rob_entry_o.opcode", 32'(rob_entry_i.opcode),
                              32'(pend_word[6:0]));
            end
        end
    end

endmodule

`default_nettype wire
